// File: Bender.yml
package:
  name: fir_filter

sources:
  - files:
      - hdl/fir_pkg.sv
      - hdl/tap_load_if.sv
      - hdl/fir_control.sv
      - hdl/coefficient_bank.sv
      - hdl/sample_delay_line.sv
      - hdl/mac_pipeline.sv
      - hdl/fir_filter_top.sv
  - target: test
    files:
      - testbench/fir_filter_tb.sv

// File: filelist.f
hdl/fir_pkg.sv
hdl/tap_load_if.sv
hdl/fir_control.sv
hdl/coefficient_bank.sv
hdl/sample_delay_line.sv
hdl/mac_pipeline.sv
hdl/fir_filter_top.sv
testbench/fir_filter_tb.sv

// File: hdl/coefficient_bank.sv
`default_nettype none
`timescale 1ns/100ps

// Coefficient register bank.
// New coefficients enter at index 0 and older ones move up.
// After TAPS loads the first coefficient sits at index TAPS-1.
module coefficient_bank #(
	parameter int TAPS = 10,
	parameter int DATA_WIDTH = 8
) (
	input wire logic clock,
	input wire logic rst,
	tap_load_if.bank taps,
	output logic [TAPS-1:0][DATA_WIDTH-1:0] coefficients
);

	// The whole bank is a single packed vector.
	// Each word is signed and is cast as such where it is multiplied.
	always_ff @(posedge clock) begin
		if (rst) begin
			coefficients <= '0;
		end else if (taps.coefficient_shift) begin
			// Shift up by one word and insert the new coefficient at the bottom.
			coefficients <= {coefficients[TAPS-2:0], taps.coefficient};
		end
	end

endmodule

`default_nettype wire

// File: hdl/fir_control.sv
`default_nettype none
`timescale 1ns/100ps

// Control FSM of the FIR filter.
// It counts the loaded coefficients, moves through the filter states and
// qualifies the host strobes, so that the receivers never look at state.
module fir_control #(
	parameter int TAPS = 10,
	parameter int DATA_WIDTH = 8
) (
	input wire logic clock,
	input wire logic rst,
	input wire logic load_coefficient,
	input wire logic signed [DATA_WIDTH-1:0] coefficient_in,
	input wire logic load_sample,
	input wire logic signed [DATA_WIDTH-1:0] sample_in,
	input wire logic stop,
	tap_load_if.control taps,
	output logic sample_accept,
	output logic filter_ready
);

	// The counter must be able to hold TAPS itself.
	localparam int COUNT_WIDTH = $clog2(TAPS + 1);

	fir_pkg::fir_state_t state;
	logic [COUNT_WIDTH-1:0] coefficient_count;
	logic coefficient_shift;
	logic sample_shift;

	// Coefficients are taken while idle or loading, and nowhere else.
	assign coefficient_shift = load_coefficient &&
		(state == fir_pkg::state_idle || state == fir_pkg::state_load_coefficients);

	// Samples are taken only while filtering.
	assign sample_shift = load_sample && (state == fir_pkg::state_filter);

	// The shift values pass straight through; only the strobes are gated.
	assign taps.coefficient_shift = coefficient_shift;
	assign taps.coefficient = coefficient_in;
	assign taps.sample_shift = sample_shift;
	assign taps.sample = sample_in;

	// The pipeline uses the same accepted strobe as its input valid.
	assign sample_accept = sample_shift;
	assign filter_ready = (state == fir_pkg::state_filter);

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= fir_pkg::state_idle;
			coefficient_count <= '0;
		end else begin
			case (state)
				fir_pkg::state_idle: begin
					// The first strobe already loads a coefficient.
					if (coefficient_shift) begin
						state <= fir_pkg::state_load_coefficients;
						coefficient_count <= coefficient_count + 1'b1;
					end
				end
				fir_pkg::state_load_coefficients: begin
					if (coefficient_shift) begin
						coefficient_count <= coefficient_count + 1'b1;
						// This strobe is the TAPS-th one, so the bank is full.
						if (coefficient_count == COUNT_WIDTH'(TAPS - 1)) begin
							state <= fir_pkg::state_filter;
						end
					end
				end
				fir_pkg::state_filter: begin
					// A sample in the same cycle as stop is still accepted.
					if (stop) begin
						state <= fir_pkg::state_stopped;
					end
				end
				fir_pkg::state_stopped: begin
					// Only reset leaves this state.
					state <= fir_pkg::state_stopped;
				end
				default: begin
					state <= fir_pkg::state_idle;
				end
			endcase
		end
	end

	// The count stops at TAPS, because loading ends on the TAPS-th strobe.
	assert property (@(posedge clock) disable iff (rst)
		coefficient_count <= COUNT_WIDTH'(TAPS));

	// A sample reaches the delay line only once the bank is full.
	assert property (@(posedge clock) disable iff (rst)
		sample_shift |-> coefficient_count == COUNT_WIDTH'(TAPS));

endmodule

`default_nettype wire

// File: hdl/fir_filter_top.sv
`default_nettype none
`timescale 1ns/100ps

// Top level of the streaming FIR filter.
// The host loads TAPS coefficients, then streams samples and gets one
// full-precision result per accepted sample, two cycles after acceptance.
module fir_filter_top #(
	parameter int TAPS = 10,
	parameter int DATA_WIDTH = 8
) (
	input wire logic clock,
	input wire logic rst,
	input wire logic load_coefficient,
	input wire logic signed [DATA_WIDTH-1:0] coefficient_in,
	input wire logic load_sample,
	input wire logic signed [DATA_WIDTH-1:0] sample_in,
	input wire logic stop,
	output logic signed [2*DATA_WIDTH+$clog2(TAPS)-1:0] result_out,
	output logic result_valid,
	output logic filter_ready
);

	// Two full-width words, plus enough bits to add TAPS products.
	localparam int ACC_WIDTH = 2 * DATA_WIDTH + $clog2(TAPS);

	logic sample_accept;
	logic [TAPS-1:0][DATA_WIDTH-1:0] coefficients;
	logic [TAPS-1:0][DATA_WIDTH-1:0] samples;

	// Shift strobes from control to the bank and the delay line.
	tap_load_if #(
		.DATA_WIDTH(DATA_WIDTH)
	) u_tap_load_if ();

	fir_control #(
		.TAPS(TAPS),
		.DATA_WIDTH(DATA_WIDTH)
	) u_fir_control (
		.clock(clock),
		.rst(rst),
		.load_coefficient(load_coefficient),
		.coefficient_in(coefficient_in),
		.load_sample(load_sample),
		.sample_in(sample_in),
		.stop(stop),
		.taps(u_tap_load_if.control),
		.sample_accept(sample_accept),
		.filter_ready(filter_ready)
	);

	coefficient_bank #(
		.TAPS(TAPS),
		.DATA_WIDTH(DATA_WIDTH)
	) u_coefficient_bank (
		.clock(clock),
		.rst(rst),
		.taps(u_tap_load_if.bank),
		.coefficients(coefficients)
	);

	sample_delay_line #(
		.TAPS(TAPS),
		.DATA_WIDTH(DATA_WIDTH)
	) u_sample_delay_line (
		.clock(clock),
		.rst(rst),
		.taps(u_tap_load_if.delay),
		.samples(samples)
	);

	// The pipeline gets the accepted strobe as its input valid.
	mac_pipeline #(
		.TAPS(TAPS),
		.DATA_WIDTH(DATA_WIDTH),
		.ACC_WIDTH(ACC_WIDTH)
	) u_mac_pipeline (
		.clock(clock),
		.rst(rst),
		.sample_accept(sample_accept),
		.samples(samples),
		.coefficients(coefficients),
		.result_out(result_out),
		.result_valid(result_valid)
	);

endmodule

`default_nettype wire

// File: hdl/fir_pkg.sv
`default_nettype none

// Shared definitions for the FIR filter block.
// Only the control state encoding lives here.
package fir_pkg;

	// Control states of the FIR filter.
	// The filter starts idle and moves to coefficient loading on the first
	// coefficient strobe.
	// Once the full set of taps is loaded it filters samples.
	// A stop strobe freezes it until the next reset.
	typedef enum logic [1:0] {
		// Waiting for the first coefficient.
		state_idle,
		// Shifting coefficients into the bank.
		state_load_coefficients,
		// Accepting samples and producing results.
		state_filter,
		// Frozen until reset.
		state_stopped
	} fir_state_t;

endpackage

`default_nettype wire

// File: hdl/mac_pipeline.sv
`default_nettype none
`timescale 1ns/100ps

// Two-stage multiply and accumulate pipeline.
// Stage one registers all TAPS products of the updated sample window.
// Stage two registers their full-precision sum.
module mac_pipeline #(
	parameter int TAPS = 10,
	parameter int DATA_WIDTH = 8,
	parameter int ACC_WIDTH = 20
) (
	input wire logic clock,
	input wire logic rst,
	input wire logic sample_accept,
	input wire logic [TAPS-1:0][DATA_WIDTH-1:0] samples,
	input wire logic [TAPS-1:0][DATA_WIDTH-1:0] coefficients,
	output logic signed [ACC_WIDTH-1:0] result_out,
	output logic result_valid
);

	// A full product of two signed words.
	localparam int PRODUCT_WIDTH = 2 * DATA_WIDTH;

	logic [1:0] valid_pipe;
	logic signed [PRODUCT_WIDTH-1:0] products [TAPS];
	logic signed [ACC_WIDTH-1:0] product_sum;

	// Bit 0 marks a window that was updated at the last edge.
	// Bit 1 marks products that belong to an accepted sample.
	// With one bit per stage, two results can be in flight at once.
	always_ff @(posedge clock) begin
		if (rst) begin
			valid_pipe <= '0;
			result_valid <= 1'b0;
		end else begin
			valid_pipe <= {valid_pipe[0], sample_accept};
			result_valid <= valid_pipe[1];
		end
	end

	// Stage one.
	// The newest sample pairs with the first loaded coefficient, which the
	// bank holds at the top index.
	always_ff @(posedge clock) begin
		if (valid_pipe[0]) begin
			for (int k = 0; k < TAPS; k++) begin
				products[k] <= $signed(samples[k]) * $signed(coefficients[TAPS-1-k]);
			end
		end
	end

	// The adder tree is sized so that no sum of TAPS products can overflow.
	always_comb begin
		product_sum = '0;
		for (int k = 0; k < TAPS; k++) begin
			product_sum = product_sum + products[k];
		end
	end

	// Stage two.
	// The result holds its value until the next accepted sample reaches it.
	always_ff @(posedge clock) begin
		if (valid_pipe[1]) begin
			result_out <= product_sum;
		end
	end

	// The valid pulse is the only thing the host can trust, so it must be clean.
	assert property (@(posedge clock) disable iff (rst) !$isunknown(result_valid));

endmodule

`default_nettype wire

// File: hdl/sample_delay_line.sv
`default_nettype none
`timescale 1ns/100ps

// Delay line of the most recent TAPS input samples.
// The newest sample is at index 0.
// Reset zeroes the window, so samples before the first one count as zero.
module sample_delay_line #(
	parameter int TAPS = 10,
	parameter int DATA_WIDTH = 8
) (
	input wire logic clock,
	input wire logic rst,
	tap_load_if.delay taps,
	output logic [TAPS-1:0][DATA_WIDTH-1:0] samples
);

	// The window updates at the accepting edge.
	// The pipeline reads the updated window in the following cycle.
	always_ff @(posedge clock) begin
		if (rst) begin
			samples <= '0;
		end else if (taps.sample_shift) begin
			// The oldest sample drops off the top.
			samples <= {samples[TAPS-2:0], taps.sample};
		end
	end

endmodule

`default_nettype wire

// File: hdl/tap_load_if.sv
`default_nettype none
`timescale 1ns/100ps

// Shift strobes and shift values from the control FSM to the two tap
// shift registers.
// The control FSM qualifies both strobes by state, so the receivers
// shift whenever their strobe is high.
interface tap_load_if #(
	parameter int DATA_WIDTH = 8
);

	// Coefficient shift strobe and the value to shift in at index 0.
	logic coefficient_shift;
	logic signed [DATA_WIDTH-1:0] coefficient;

	// Sample shift strobe and the value to shift in at index 0.
	logic sample_shift;
	logic signed [DATA_WIDTH-1:0] sample;

	// The control FSM drives every signal.
	modport control (output coefficient_shift, output coefficient,
		output sample_shift, output sample);

	// The coefficient bank only sees the coefficient half.
	modport bank (input coefficient_shift, input coefficient);

	// The sample delay line only sees the sample half.
	modport delay (input sample_shift, input sample);

endinterface

`default_nettype wire

// File: testbench/fir_filter_tb.sv
`default_nettype none
`timescale 1ns/100ps

// Random-stimulus testbench for the streaming FIR filter.
// A model in the testbench keeps its own coefficients and sample window and queues
// the expected convolution result for every sample the DUT should accept.
module fir_filter_tb;

	localparam int TAPS = 10;
	localparam int DATA_WIDTH = 8;
	localparam int ACC_WIDTH = 2 * DATA_WIDTH + $clog2(TAPS);
	localparam int READY_TIMEOUT = 20;
	localparam int DRAIN_TIMEOUT = 20;

	logic clock;
	logic rst;
	logic load_coefficient;
	logic signed [DATA_WIDTH-1:0] coefficient_in;
	logic load_sample;
	logic signed [DATA_WIDTH-1:0] sample_in;
	logic stop;
	logic signed [ACC_WIDTH-1:0] result_out;
	logic result_valid;
	logic filter_ready;

	// Model state, stimulus generator state and counters.
	fir_pkg::fir_state_t model_state;
	logic signed [DATA_WIDTH-1:0] coef_model [TAPS];
	logic signed [DATA_WIDTH-1:0] window_model [TAPS];
	logic signed [ACC_WIDTH-1:0] expected_results [$];
	logic [31:0] rng_state;
	int coefficients_loaded;
	int samples_accepted;
	int results_seen;
	int value_errors;
	int other_errors;

	fir_filter_top u_fir_filter_top (
		.clock(clock),
		.rst(rst),
		.load_coefficient(load_coefficient),
		.coefficient_in(coefficient_in),
		.load_sample(load_sample),
		.sample_in(sample_in),
		.stop(stop),
		.result_out(result_out),
		.result_valid(result_valid),
		.filter_ready(filter_ready)
	);

	// Period of 8 ns.
	always #4 clock = ~clock;

	// Xorshift generator; the state lives at module level so every call advances it.
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	function automatic logic signed [DATA_WIDTH-1:0] random_word();
		logic [31:0] r;
		r = next_random();
		return r[DATA_WIDTH-1:0];
	endfunction

	// Sum of h_k times x_(n-k), with h_k the k-th coefficient loaded and x_n the newest sample.
	function automatic logic signed [ACC_WIDTH-1:0] convolution();
		int sum;
		sum = 0;
		for (int k = 0; k < TAPS; k++) begin
			sum += coef_model[k] * window_model[k];
		end
		return sum[ACC_WIDTH-1:0];
	endfunction

	task automatic check_result(input logic signed [ACC_WIDTH-1:0] expected);
		if (result_out !== expected) begin
			value_errors++;
			$display("** Error at %0t: result_out is %0d, expected %0d", $time, result_out, expected);
		end
	endtask

	task automatic check_ready(input logic expected);
		if (filter_ready !== expected) begin
			value_errors++;
			$display("** Error at %0t: filter_ready is %b, expected %b", $time, filter_ready, expected);
		end
	endtask

	// Drives one cycle of inputs from a falling edge, lets the rising edge take them,
	// then updates the model the way the control FSM should have reacted.
	task automatic step_cycle(input logic coef_strobe, input logic signed [DATA_WIDTH-1:0] coef,
			input logic sample_strobe, input logic signed [DATA_WIDTH-1:0] sample,
			input logic stop_strobe);
		load_coefficient = coef_strobe;
		coefficient_in = coef;
		load_sample = sample_strobe;
		sample_in = sample;
		stop = stop_strobe;
		@(negedge clock);
		case (model_state)
			fir_pkg::state_idle, fir_pkg::state_load_coefficients: begin
				if (coef_strobe) begin
					coef_model[coefficients_loaded] = coef;
					coefficients_loaded++;
					if (coefficients_loaded == TAPS) begin
						model_state = fir_pkg::state_filter;
					end else begin
						model_state = fir_pkg::state_load_coefficients;
					end
				end
			end
			fir_pkg::state_filter: begin
				if (sample_strobe) begin
					for (int k = TAPS - 1; k > 0; k--) begin
						window_model[k] = window_model[k-1];
					end
					window_model[0] = sample;
					expected_results.push_back(convolution());
					samples_accepted++;
				end
				// A sample in the same cycle as stop still counts.
				if (stop_strobe) begin
					model_state = fir_pkg::state_stopped;
				end
			end
			default: begin
			end
		endcase
		check_ready(model_state == fir_pkg::state_filter);
	endtask

	// Zero to three cycles with optional stray strobes that the DUT must ignore.
	task automatic random_gap(input logic stray_coefficient, input logic stray_sample);
		logic [31:0] r;
		int gap;
		r = next_random();
		gap = r % 4;
		for (int g = 0; g < gap; g++) begin
			r = next_random();
			step_cycle(stray_coefficient && r[2:0] == 3'd0, r[15:8],
				stray_sample && r[5:3] == 3'd0, r[23:16], 1'b0);
		end
	endtask

	task automatic wait_for_ready();
		int cycles;
		cycles = 0;
		while (filter_ready !== 1'b1 && cycles < READY_TIMEOUT) begin
			step_cycle(1'b0, '0, 1'b0, '0, 1'b0);
			cycles++;
		end
		if (filter_ready !== 1'b1) begin
			other_errors++;
			$display("Timed out after %0d cycles waiting for filter_ready to rise", cycles);
		end
	endtask

	task automatic wait_for_drain();
		int cycles;
		cycles = 0;
		while (expected_results.size() != 0 && cycles < DRAIN_TIMEOUT) begin
			step_cycle(1'b0, '0, 1'b0, '0, 1'b0);
			cycles++;
		end
		if (expected_results.size() != 0) begin
			other_errors++;
			$display("Timed out with %0d results still missing", expected_results.size());
		end
	endtask

	// Every result pulse must match the oldest expected value, and no pulse may come
	// without a pending sample.
	always @(negedge clock) begin
		if (result_valid === 1'b1) begin
			results_seen++;
			if (expected_results.size() == 0) begin
				other_errors++;
				$display("Result pulse at %0t with no accepted sample pending", $time);
			end else begin
				check_result(expected_results.pop_front());
			end
		end
	end

	initial begin
		clock = 1'b0;
		rst = 1'b1;
		load_coefficient = 1'b0;
		coefficient_in = '0;
		load_sample = 1'b0;
		sample_in = '0;
		stop = 1'b0;
		rng_state = 32'h3666268c;
		model_state = fir_pkg::state_idle;
		coefficients_loaded = 0;
		samples_accepted = 0;
		results_seen = 0;
		value_errors = 0;
		other_errors = 0;
		for (int k = 0; k < TAPS; k++) begin
			coef_model[k] = '0;
			window_model[k] = '0;
		end
		repeat (8) begin
			@(negedge clock);
			check_ready(1'b0);
		end
		rst = 1'b0;

		// Samples and stops before any coefficient must do nothing.
		for (int i = 0; i < 6; i++) begin
			step_cycle(1'b0, '0, 1'b1, random_word(), i == 3);
		end

		// Load the taps with random gaps and stray samples between them.
		for (int i = 0; i < TAPS; i++) begin
			random_gap(1'b0, 1'b1);
			step_cycle(1'b1, random_word(), 1'b0, '0, 1'b0);
		end
		wait_for_ready();

		// Random samples with gaps, mixed with stray coefficient strobes.
		for (int i = 0; i < 200; i++) begin
			random_gap(1'b1, 1'b0);
			step_cycle(1'b0, '0, 1'b1, random_word(), 1'b0);
		end

		// Back-to-back burst keeps two results in flight.
		for (int i = 0; i < 40; i++) begin
			step_cycle(1'b0, '0, 1'b1, random_word(), 1'b0);
		end
		wait_for_drain();

		// Stop with a final sample, then watch for any further result.
		step_cycle(1'b0, '0, 1'b1, random_word(), 1'b1);
		wait_for_drain();
		for (int i = 0; i < 50; i++) begin
			step_cycle(1'b0, '0, i % 2 == 0, random_word(), 1'b0);
		end

		if (results_seen != samples_accepted) begin
			other_errors++;
			$display("Saw %0d result pulses for %0d accepted samples", results_seen,
				samples_accepted);
		end
		$display("Errors: %0d value, %0d other; %0d results for %0d samples", value_errors,
			other_errors, results_seen, samples_accepted);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
